// File: audio_recorder.f
common/recorder_pkg.sv
common/sample_mem_if.sv
hw/debounce.sv
panel/panel_control.sv
recorder/recorder_control.sv
recorder/sample_mem.sv
hw/audio_recorder.sv
dv/audio_recorder_chk.sv
dv/audio_recorder_tb.sv

// File: Bender.yml
package:
  name: audio_recorder

sources:
  # design, in compile order
  - common/recorder_pkg.sv
  - common/sample_mem_if.sv
  - hw/debounce.sv
  - panel/panel_control.sv
  - recorder/recorder_control.sv
  - recorder/sample_mem.sv
  - hw/audio_recorder.sv

  # verification
  - target: test
    files:
      - dv/audio_recorder_chk.sv
      - dv/audio_recorder_tb.sv

// File: dv/audio_recorder_tb.sv
`timescale 1ns/100ps

module audio_recorder_tb;
  import recorder_pkg::*;

  localparam int TB_DEBOUNCE = 16;    // short debounce so a press fits in 40 clocks
  localparam int HOLD_CLOCKS = 40;    // press and release time per button action
  localparam int WAIT_LIMIT  = 200;   // clocks before a wait gives up
  localparam int NUM_ROWS    = 7;

  // table operations
  localparam int OP_UP     = 0;
  localparam int OP_DOWN   = 1;
  localparam int OP_RECORD = 2;
  localparam int OP_PLAY   = 3;

  logic       clock, reset;
  logic       button_up, button_down, button_enter;
  logic       sample_ready;
  sample_t    sample_in, sample_out;
  volume_t    attenuation;
  logic [7:0] led;

  // stimulus table, one row per test
  int op_tab    [NUM_ROWS];
  int count_tab [NUM_ROWS];      // presses or sample periods
  int vol_tab   [NUM_ROWS];      // volume expected once the row is done

  // reference model
  sample_t mem_model [MEM_DEPTH];
  int      stored, length, play_addr, dec, volume_model;
  mode_t   mode_model;

  int     pass_count, fail_count, test_errors;
  integer seed;

  audio_recorder #(.DEBOUNCE_CYCLES(TB_DEBOUNCE)) u_audio_recorder (
    .clock        (clock),
    .reset        (reset),
    .button_up    (button_up),
    .button_down  (button_down),
    .button_enter (button_enter),
    .sample_ready (sample_ready),
    .sample_in    (sample_in),
    .sample_out   (sample_out),
    .attenuation  (attenuation),
    .led          (led)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;   // 100 ns period
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  // waits for attenuation to settle, then checks it
  task automatic settle_attenuation(input int volume);
    logic [7:0] expected;
    int         i;
    expected = 8'(int'(VOLUME_MAX) - volume);
    i        = 0;
    @(negedge clock);
    while (attenuation !== expected[4:0] && i < WAIT_LIMIT) begin
      @(negedge clock);
      i++;
    end
    check_value("attenuation", expected, {3'b000, attenuation});
  endtask

  task automatic press_button(input int op);
    @(posedge clock);
    if (op == OP_UP)
      button_up <= 1'b0;            // buttons are active low
    else
      button_down <= 1'b0;
    repeat (HOLD_CLOCKS) @(posedge clock);
    button_up   <= 1'b1;
    button_down <= 1'b1;
    repeat (HOLD_CLOCKS) @(posedge clock);
  endtask

  // move enter and wait for the led pattern of the new mode
  task automatic set_mode(input mode_t target);
    logic [7:0] led_expected;
    int         i;
    if (target != mode_model) begin
      if (target == mode_playback)
        led_expected = ~{3'b000, 5'(volume_model)};
      else
        led_expected = ~{1'b0, 7'h7f};
      @(posedge clock);
      button_enter <= (target == mode_playback);
      i = 0;
      @(negedge clock);
      while (led !== led_expected && i < WAIT_LIMIT) begin
        @(negedge clock);
        i++;
      end
      if (led !== led_expected) begin
        $display("timeout: led never switched to the new mode pattern at %0t", $time);
        fail_count++;
        test_errors++;
      end
      // mode change restarts the sequencing
      mode_model = target;
      dec        = 0;
      play_addr  = 0;
      if (target == mode_playback)
        length = stored;
      else
        stored = 0;
    end
  endtask

  // one 16 clock sample period, returns at the negedge before the next strobe
  task automatic strobe_period(input sample_t value);
    @(posedge clock);
    sample_ready <= 1'b1;
    sample_in    <= value;
    @(posedge clock);
    sample_ready <= 1'b0;
    repeat (14) @(posedge clock);
    @(negedge clock);
  endtask

  function automatic string op_name(input int op);
    case (op)
      OP_UP:     return "volume up";
      OP_DOWN:   return "volume down";
      OP_RECORD: return "record";
      default:   return "playback";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    sample_t value, expected;
    int      row, n;
    reset        = 1'b1;
    button_up    = 1'b1;
    button_down  = 1'b1;
    button_enter = 1'b0;
    sample_ready = 1'b0;
    sample_in    = '0;
    seed         = 32'h0295_493a;
    pass_count   = 0;
    fail_count   = 0;
    volume_model = int'(VOLUME_RESET);
    mode_model   = mode_record;
    stored       = 0;
    length       = 0;
    play_addr    = 0;
    dec          = 0;

    op_tab    = '{OP_UP, OP_DOWN, OP_UP, OP_RECORD, OP_PLAY, OP_RECORD, OP_PLAY};
    count_tab = '{30, 35, 5, 80, 100, 40, 50};
    vol_tab   = '{31, 0, 5, 5, 5, 5, 5};

    repeat (16) @(posedge clock);
    reset <= 1'b0;

    test_errors = 0;
    settle_attenuation(volume_model);
    check_value("led", ~{1'b0, 7'h7f}, led);    // record pattern
    $display("test 0 reset state: %0d error(s)", test_errors);

    for (row = 0; row < NUM_ROWS; row++) begin
      test_errors = 0;
      case (op_tab[row])
        OP_UP, OP_DOWN: begin
          for (n = 0; n < count_tab[row]; n++) begin
            press_button(op_tab[row]);
            if (op_tab[row] == OP_UP && volume_model < int'(VOLUME_MAX))
              volume_model++;
            else if (op_tab[row] == OP_DOWN && volume_model > 0)
              volume_model--;
            settle_attenuation(volume_model);
          end
        end
        OP_RECORD: begin
          set_mode(mode_record);
          for (n = 0; n < count_tab[row]; n++) begin
            value = sample_t'($random(seed));
            strobe_period(value);
            if (dec == 0 && stored < MEM_DEPTH) begin
              mem_model[stored] = value;     // every eighth sample is kept
              stored++;
            end
            dec = (dec + 1) % DECIMATION;
            check_value("sample_out", value, sample_out);   // loopback
          end
        end
        default: begin
          set_mode(mode_playback);
          check_value("led", ~{3'b000, 5'(vol_tab[row])}, led);
          for (n = 0; n < count_tab[row]; n++) begin
            strobe_period(sample_t'($random(seed)));
            if (dec == 0 && length != 0)
              play_addr = (play_addr + 1) % length;   // wrap at the recording end
            dec      = (dec + 1) % DECIMATION;
            expected = (length == 0) ? sample_t'(0) : mem_model[play_addr];
            check_value("sample_out", expected, sample_out);
          end
        end
      endcase
      settle_attenuation(vol_tab[row]);   // table volume after the row
      $display("test %0d %s x%0d: %0d error(s)", row + 1, op_name(op_tab[row]),
               count_tab[row], test_errors);
    end

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: dv/audio_recorder_chk.sv
`timescale 1ns/100ps

// protocol checks on the recorder control memory port
module audio_recorder_chk (
  input logic                    clock,
  input logic                    reset,
  input recorder_pkg::mode_t     mode,
  input recorder_pkg::mode_t     mode_q,   // mode the sequencing last saw
  input logic                    write,    // memory write strobe
  input recorder_pkg::mem_addr_t addr      // record or playback position
);
  import recorder_pkg::*;

  ////////////////////////////////////////////////////////////
  // memory port
  ////////////////////////////////////////////////////////////

  // memory is read only while the sequencing plays back
  a_no_write_in_playback: assert property (
    @(posedge clock) disable iff (reset) (mode_q == mode_playback) |-> !write
  ) else $error("memory write seen in playback mode");

  a_write_low_in_reset: assert property (
    @(posedge clock) reset |=> !write     // sync reset, visible one edge later
  ) else $error("memory write high during reset");

  // address restarts on every mode switch
  a_addr_zero_after_mode_change: assert property (
    @(posedge clock) disable iff (reset) (mode != $past(mode)) |=> (addr == '0)
  ) else $error("address not zero after a mode change");

endmodule

bind recorder_control audio_recorder_chk u_audio_recorder_chk (
  .clock  (clock),
  .reset  (reset),
  .mode   (mode),
  .mode_q (mode_q),
  .write  (mem.write),
  .addr   (addr)
);

// File: hw/audio_recorder.sv
`timescale 1ns/100ps

// voice recorder top level
// sits between the codec sample stream and the button panel
module audio_recorder #(
  parameter int DEBOUNCE_CYCLES = recorder_pkg::DEBOUNCE_CYCLES_DEFAULT
) (
  input  logic                  clock,
  input  logic                  reset,         // synchronous, active high
  input  logic                  button_up,     // active low
  input  logic                  button_down,   // active low
  input  logic                  button_enter,  // held for playback
  input  logic                  sample_ready,  // codec ready, one clock wide
  input  recorder_pkg::sample_t sample_in,
  output recorder_pkg::sample_t sample_out,
  output recorder_pkg::volume_t attenuation,   // to the codec volume register
  output logic [7:0]            led            // active low
);
  import recorder_pkg::*;

  mode_t mode;        // panel to recorder

  sample_mem_if mem_bus ();

  //////////////////////////////////////////////////////////////
  // button panel
  //////////////////////////////////////////////////////////////

  panel_control #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_panel_control (
    .clock        (clock),
    .reset        (reset),
    .button_up    (button_up),
    .button_down  (button_down),
    .button_enter (button_enter),
    .mode         (mode),
    .attenuation  (attenuation),
    .led          (led)
  );

  //////////////////////////////////////////////////////////////
  // record and playback
  //////////////////////////////////////////////////////////////

  recorder_control u_recorder_control (
    .clock        (clock),
    .reset        (reset),
    .mode         (mode),
    .sample_ready (sample_ready),
    .sample_in    (sample_in),
    .sample_out   (sample_out),
    .mem          (mem_bus.ctrl)
  );

  sample_mem u_sample_mem (
    .clock (clock),
    .port  (mem_bus.mem)    // answers the control side
  );

endmodule

// File: recorder/sample_mem.sv
`timescale 1ns/100ps

// MEM_DEPTH x sample_t single port block ram
// read is registered, read during write returns the old word
module sample_mem (
  input  logic       clock,
  sample_mem_if.mem  port
);
  import recorder_pkg::*;

  sample_t ram [MEM_DEPTH];   // one word per stored sample

  //////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (port.write)
      ram[port.addr] <= port.wdata;   // store the new sample
    port.rdata <= ram[port.addr];     // old word on a same-cycle write
  end

  // both halves share the one address, so a single port is enough
  // addr width covers MEM_DEPTH exactly, no out of range access

endmodule

// File: recorder/recorder_control.sv
`timescale 1ns/100ps

// record and playback sequencing over the sample memory
module recorder_control (
  input  logic                  clock,
  input  logic                  reset,
  input  recorder_pkg::mode_t   mode,
  input  logic                  sample_ready,  // one clock per sample period
  input  recorder_pkg::sample_t sample_in,
  output recorder_pkg::sample_t sample_out,
  sample_mem_if.ctrl            mem
);
  import recorder_pkg::*;

  // sample count, one bit wider than the address so a full memory fits
  typedef logic [$clog2(MEM_DEPTH):0] length_t;

  mode_t      mode_q;     // mode at the previous clock
  mem_addr_t  addr;       // record or playback position
  dec_count_t dec_count;  // strobes since the last stored sample
  logic       write_q;    // pending write, one clock after the strobe
  logic       full;       // address wrapped, MEM_DEPTH samples held
  length_t    length;     // recording length, latched entering playback
  length_t    stored;     // samples written so far in this recording
  sample_t    wdata_q;
  sample_t    loop_q;     // record loopback sample
  logic       dec_zero;

  assign stored   = {full, addr};
  assign dec_zero = (dec_count == '0);

  //////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      mode_q    <= mode;                  // no mode change seen out of reset
      addr      <= '0;
      dec_count <= '0;
      write_q   <= 1'b0;
      full      <= 1'b0;
      length    <= '0;
      loop_q    <= '0;
    end else if (mode != mode_q) begin
      // any mode change restarts from address zero
      mode_q    <= mode;
      addr      <= '0;
      dec_count <= '0;
      write_q   <= 1'b0;
      full      <= 1'b0;
      if (mode == mode_playback)
        length <= stored;                 // what was recorded becomes the loop
    end else begin
      if (sample_ready)                   // decimation count runs in both modes
        dec_count <= (dec_count == dec_count_t'(DECIMATION - 1)) ? '0 : dec_count + 1'b1;

      if (mode == mode_record) begin
        if (sample_ready) begin
          loop_q <= sample_in;            // loopback to the output
          if (dec_zero && !full)
            write_q <= 1'b1;
        end
        if (write_q) begin
          // write lands this clock, then step to the next word
          write_q <= 1'b0;
          addr    <= addr + 1'b1;
          if (addr == mem_addr_t'(MEM_DEPTH - 1))
            full <= 1'b1;                 // stop here, memory is used up
        end
      end else if (sample_ready && dec_zero && length != '0) begin
        // playback step, wrap at the end of the recording
        if (length_t'(addr) + length_t'(1) == length)
          addr <= '0;
        else
          addr <= addr + 1'b1;
      end
    end
  end

  // write data, captured on every strobe
  always_ff @(posedge clock) begin
    if (sample_ready)
      wdata_q <= sample_in;
  end

  //////////////////////////////////////////////////////////////
  // memory port and output select
  //////////////////////////////////////////////////////////////

  assign mem.addr  = addr;
  assign mem.wdata = wdata_q;
  assign mem.write = write_q & (mode == mode_record);  // dropped if enter goes down

  // playback reads straight off the memory, silent with no recording
  assign sample_out = (mode_q == mode_playback) ?
                      ((length == '0) ? sample_t'(0) : mem.rdata) :
                      loop_q;

endmodule

// File: panel/panel_control.sv
`timescale 1ns/100ps

// button panel: debounce, volume register, mode and led drive
module panel_control #(
  parameter int DEBOUNCE_CYCLES = recorder_pkg::DEBOUNCE_CYCLES_DEFAULT
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  button_up,     // active low
  input  logic                  button_down,   // active low
  input  logic                  button_enter,  // high while held
  output recorder_pkg::mode_t   mode,
  output recorder_pkg::volume_t attenuation,
  output logic [7:0]            led            // active low
);
  import recorder_pkg::*;

  logic    up_clean, down_clean, enter_clean;  // debounced, active high
  logic    up_prev, down_prev;                 // last clock, for edge detect
  logic    up_rise, down_rise;
  volume_t volume;

  //////////////////////////////////////////////////////////////
  // debounce
  //////////////////////////////////////////////////////////////

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce_up (
    .clock (clock),
    .reset (reset),
    .noisy (~button_up),     // invert, pressed reads as 1
    .clean (up_clean)
  );

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce_down (
    .clock (clock),
    .reset (reset),
    .noisy (~button_down),
    .clean (down_clean)
  );

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce_enter (
    .clock (clock),
    .reset (reset),
    .noisy (button_enter),   // already active high
    .clean (enter_clean)
  );

  assign mode = enter_clean ? mode_playback : mode_record;

  //////////////////////////////////////////////////////////////
  // volume
  //////////////////////////////////////////////////////////////

  // previous debounced levels for the edge detect
  always_ff @(posedge clock) begin
    up_prev   <= up_clean;
    down_prev <= down_clean;
  end

  assign up_rise   = up_clean & ~up_prev;
  assign down_rise = down_clean & ~down_prev;

  always_ff @(posedge clock) begin
    if (reset) begin
      volume <= VOLUME_RESET;
    end else if (up_rise && volume != VOLUME_MAX) begin
      volume <= volume + 1'b1;            // saturate at the top
    end else if (down_rise && volume != '0) begin
      volume <= volume - 1'b1;            // and at zero
    end
  end

  // outputs trail volume and mode by one clock
  always_ff @(posedge clock) begin
    attenuation <= VOLUME_MAX - volume;
    if (mode == mode_playback)
      led <= ~{3'b000, volume};           // show volume while playing
    else
      led <= ~{1'b0, 7'h7f};              // all but led[7] lit while recording
  end

endmodule

// File: hw/debounce.sv
`timescale 1ns/100ps

// stability filter for one mechanical contact
// clean follows noisy once noisy has held still for DEBOUNCE_CYCLES + 1 clocks
module debounce #(
  parameter int DEBOUNCE_CYCLES = recorder_pkg::DEBOUNCE_CYCLES_DEFAULT
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // wide enough to hold DEBOUNCE_CYCLES itself
  typedef logic [$clog2(DEBOUNCE_CYCLES + 1)-1:0] count_t;

  count_t count;     // clocks since noisy last moved
  logic   last_seen; // value of noisy at the previous clock

  always_ff @(posedge clock) begin
    if (reset) begin
      count     <= '0;
      last_seen <= noisy;                 // start out settled on the current level
      clean     <= noisy;
    end else if (noisy != last_seen) begin
      // contact bounced, start timing again
      last_seen <= noisy;
      count     <= '0;
    end else if (count == count_t'(DEBOUNCE_CYCLES)) begin
      clean <= last_seen;                 // stable long enough, pass it on
    end else begin
      count <= count + 1'b1;              // still waiting
    end
  end

  // count parks at DEBOUNCE_CYCLES while the input holds,
  // so clean keeps tracking last_seen without a further wait

endmodule

// File: common/sample_mem_if.sv
`timescale 1ns/100ps

// single port between the recorder control and the sample memory
// rdata is the word at the addr of the previous clock
// a write in the same cycle as a read returns the old word
interface sample_mem_if;
  import recorder_pkg::*;

  mem_addr_t addr;   // word address, held by the control side
  logic      write;  // write strobe, one cycle per stored sample
  sample_t   wdata;  // data to store
  sample_t   rdata;  // registered read data

  // control side drives the port
  modport ctrl (
    output addr,
    output write,
    output wdata,
    input  rdata
  );

  // memory side answers it
  modport mem (
    input  addr,
    input  write,
    input  wdata,
    output rdata
  );

endinterface

// File: common/recorder_pkg.sv
package recorder_pkg;

  //////////////////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////////////////

  typedef logic [7:0] sample_t;              // one 8-bit pcm sample

  localparam int MEM_DEPTH  = 256;           // stored samples, one per decimation period
  localparam int DECIMATION = 8;             // sample periods per stored sample

  typedef logic [$clog2(MEM_DEPTH)-1:0]  mem_addr_t;   // sample memory address
  typedef logic [$clog2(DECIMATION)-1:0] dec_count_t;  // wraps once per stored sample

  //////////////////////////////////////////////////////////////
  // button panel
  //////////////////////////////////////////////////////////////

  // headphone volume, 0 is quietest
  // codec wants attenuation, which is VOLUME_MAX - volume in the same width
  typedef logic [4:0] volume_t;

  localparam volume_t VOLUME_RESET = 5'd8;   // volume after reset
  localparam volume_t VOLUME_MAX   = 5'd31;  // saturation point going up

  // about 10 ms at 27 MHz
  localparam int DEBOUNCE_CYCLES_DEFAULT = 270000;

  //////////////////////////////////////////////////////////////
  // operating mode
  //////////////////////////////////////////////////////////////

  // enter released records, enter held plays back
  typedef enum logic {
    mode_record   = 1'b0,
    mode_playback = 1'b1
  } mode_t;

endpackage
